/* Bender.yml */
package:
  name: stmcu

sources:
  - hw/stmcu_bus_pkg.sv
  - hw/stmcu_video_pkg.sv
  - hw/clock_enables.sv
  - hw/addr_decode.sv
  - hw/bus_error_timer.sv
  - hw/shifter_regs.sv
  - hw/sync_gen.sv
  - hw/video_addr_counter.sv
  - hw/stmcu_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/stmcu_tb.sv

/* hw/addr_decode.sv */
// CPU address decoder giving ROM and MFP selects, video register select and DTACK
`timescale 1ns/1ns

module addr_decode import stmcu_bus_pkg::*; (
    input  addr_t      a_i,
    input  logic       as_n_i,
    input  logic       rw_i,
    input  logic       uds_n_i,
    input  logic       lds_n_i,
    output logic [4:0] rom_n_o,
    output logic       mfpcs_n_o,
    output reg_sel_t   reg_sel_o,
    output logic       reg_wr_o,
    output logic       reg_rd_o,
    output logic       dtack_n_o
);

    logic       as, uds, lds;
    logic       tos_hit, cart_hit, vreg_hit;
    logic       reg_hit;
    logic [4:0] rom;

    assign as  = ~as_n_i;
    assign uds = ~uds_n_i;
    assign lds = ~lds_n_i;

    // ====================
    // ROM and peripheral windows
    assign tos_hit  = as & rw_i & (a_i[23:20] == ROM_TOS_BASE[7:4]);
    assign cart_hit = as & rw_i & (a_i[23:17] == ROM_CART_BASE[7:1]);
    assign vreg_hit = as & (a_i[23:8] == VREG_BASE[23:8]);

    assign rom[0] = tos_hit & (a_i[19:18] == 2'b10);  // E8-EB
    assign rom[1] = tos_hit & (a_i[19:18] == 2'b01);  // E4-E7
    assign rom[2] = tos_hit & (a_i[19:18] == 2'b00);  // E0-E3
    assign rom[3] = cart_hit & a_i[16];
    assign rom[4] = cart_hit & ~a_i[16];
    assign rom_n_o = ~rom;

    assign mfpcs_n_o = ~(as & (a_i[23:6] == MFP_BASE[23:6]));

    // Word offset within the page plus the lane the register lives on
    always_comb begin
        reg_sel_o = REG_NONE;
        if (vreg_hit) begin
            case (a_i[7:1])
                7'h00: if (lds) reg_sel_o = REG_BASE_HI;
                7'h01: if (lds) reg_sel_o = REG_BASE_MID;
                7'h02: if (lds) reg_sel_o = REG_CNT_HI;
                7'h03: if (lds) reg_sel_o = REG_CNT_MID;
                7'h04: if (lds) reg_sel_o = REG_CNT_LO;
                7'h05: if (uds) reg_sel_o = REG_SYNC;
                7'h06: if (lds) reg_sel_o = REG_BASE_LO;
                7'h07: if (lds) reg_sel_o = REG_OFFSET;
                7'h30: if (uds) reg_sel_o = REG_RES;
                default: reg_sel_o = REG_NONE;
            endcase
        end
    end

    assign reg_hit  = reg_sel_o != REG_NONE;
    assign reg_wr_o = reg_hit & ~rw_i;
    assign reg_rd_o = reg_hit & rw_i;

    // MFP answers its own cycles
    assign dtack_n_o = ~(|rom | reg_hit);

endmodule

/* hw/bus_error_timer.sv */
// Bus-error timer raising BERR when an address strobe is held too long
`timescale 1ns/1ns

module bus_error_timer import stmcu_bus_pkg::*; #(
    parameter int BERR_LIMIT = BERR_TICKS
) (
    input  logic clk32,
    input  logic porb,
    input  logic mhz8_en_i,
    input  logic as_n_i,
    input  logic br_n_i,
    output logic berr_n_o
);

    localparam int CW = $clog2(BERR_LIMIT + 1);

    logic [CW-1:0] cnt;
    logic          expired;

    assign expired  = cnt == CW'(BERR_LIMIT);
    assign berr_n_o = ~expired;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            cnt <= '0;
        end else if (as_n_i || !br_n_i) begin
            cnt <= '0;                  // No cycle, or bus handed to a master
        end else if (mhz8_en_i && !expired) begin
            cnt <= cnt + CW'(1);        // Saturates at the limit
        end
    end

endmodule

/* hw/clock_enables.sv */
// Clock-enable chain deriving the 8 MHz and 2 MHz pulses from clk32
`timescale 1ns/1ns

module clock_enables (
    input  logic clk32,
    input  logic porb,
    output logic mhz8_en_o,
    output logic m2_en_o
);

    logic [3:0] div;  // Free running, one 2 MHz period per wrap

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            div       <= 4'd0;
            mhz8_en_o <= 1'b0;
            m2_en_o   <= 1'b0;
        end else begin
            div <= div + 4'd1;
            // Pulses are registered, so the first one lands
            // 4 resp. 16 cycles after reset release
            mhz8_en_o <= div[1:0] == 2'b11;
            m2_en_o   <= div == 4'hF;       // Always with an 8 MHz pulse
        end
    end

endmodule

/* hw/shifter_regs.sv */
// Video base, line offset, sync and resolution registers with byte-lane readback
`timescale 1ns/1ns

module shifter_regs import stmcu_bus_pkg::*, stmcu_video_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  reg_sel_t    reg_sel_i,
    input  logic        reg_wr_i,
    input  logic        reg_rd_i,
    input  logic [15:0] din_i,
    input  addr_t       vaddr_i,
    output logic [15:0] dout_o,
    output addr_t       vbase_o,
    output logic [7:0]  hoff_o,
    output vmode_t      vmode_o
);

    logic [7:0] base_hi;
    logic [7:0] base_mid;
    logic [7:1] base_lo;   // Base is word aligned
    logic       pal;       // 50 Hz when set
    logic [1:0] res;       // 00 low, 01 medium, 1x high

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            base_hi  <= 8'd0;
            base_mid <= 8'd0;
            base_lo  <= 7'd0;
            hoff_o   <= 8'd0;
            pal      <= 1'b0;
            res      <= 2'b00;
        end else if (reg_wr_i) begin
            case (reg_sel_i)
                REG_BASE_HI:  base_hi  <= din_i[7:0];
                REG_BASE_MID: base_mid <= din_i[7:0];
                REG_BASE_LO:  base_lo  <= din_i[7:1];
                REG_OFFSET:   hoff_o   <= din_i[7:0];
                REG_SYNC:     pal      <= din_i[9];
                REG_RES:      res      <= din_i[9:8];
                default:      ;   // Counter bytes live in the address counter
            endcase
        end
    end

    assign vbase_o = {base_hi, base_mid, base_lo};
    assign vmode_o = res[1] ? VM_MONO : (pal ? VM_PAL : VM_NTSC);

    // ====================
    // Readback, undriven bits float high
    always_comb begin
        dout_o = 16'hFFFF;
        if (reg_rd_i) begin
            case (reg_sel_i)
                REG_BASE_HI:  dout_o[7:0]  = base_hi;
                REG_BASE_MID: dout_o[7:0]  = base_mid;
                REG_BASE_LO:  dout_o[7:0]  = {base_lo, 1'b0};
                REG_OFFSET:   dout_o[7:0]  = hoff_o;
                REG_SYNC:     dout_o[9]    = pal;
                REG_RES:      dout_o[9:8]  = res;
                REG_CNT_HI:   dout_o[7:0]  = vaddr_i[23:16];
                REG_CNT_MID:  dout_o[7:0]  = vaddr_i[15:8];
                REG_CNT_LO:   dout_o[7:0]  = {vaddr_i[7:1], 1'b0};
                default:      dout_o       = 16'hFFFF;
            endcase
        end
    end

endmodule

/* hw/stmcu_bus_pkg.sv */
// Bus-side definitions of the MCU: address map, bus-error limit and video register selects
package stmcu_bus_pkg;

    typedef logic [23:1] addr_t;  // CPU word address

    // Video register picked by the decoder
    typedef enum logic [3:0] {
        REG_NONE,
        REG_BASE_HI,   // FF8201
        REG_BASE_MID,  // FF8203
        REG_BASE_LO,   // FF820D
        REG_OFFSET,    // FF820F
        REG_SYNC,      // FF820A, upper lane
        REG_RES,       // FF8260, upper lane
        REG_CNT_HI,    // FF8205
        REG_CNT_MID,   // FF8207
        REG_CNT_LO     // FF8209
    } reg_sel_t;

    // ====================
    // Address map
    localparam logic [7:0]  ROM_TOS_BASE  = 8'hE0;       // E0-E3 ROM2, E4-E7 ROM1, E8-EB ROM0
    localparam logic [7:0]  ROM_CART_BASE = 8'hFA;       // FA ROM4, FB ROM3
    localparam logic [23:0] MFP_BASE      = 24'hFFFA00;  // Up to FFFA3F
    localparam logic [23:0] VREG_BASE     = 24'hFF8200;

    localparam int BERR_TICKS = 64;  // 8 MHz ticks, 8 us of strobe

endpackage

/* hw/stmcu_top.sv */
// MCU top level joining bus decode, video registers and video timing to the pins
`timescale 1ns/1ns

module stmcu_top import stmcu_bus_pkg::*, stmcu_video_pkg::*; #(
    parameter int BERR_LIMIT = BERR_TICKS
) (
    input  logic        clk32,
    input  logic        porb,
    input  addr_t       a_i,
    input  logic        as_n_i,
    input  logic        rw_i,
    input  logic        uds_n_i,
    input  logic        lds_n_i,
    input  logic        br_n_i,
    input  logic [15:0] din_i,
    output logic [15:0] dout_o,
    output logic        dtack_n_o,
    output logic        berr_n_o,
    output logic [4:0]  rom_n_o,     // ROM0 to ROM4
    output logic        mfpcs_n_o,
    output logic        hsync_n_o,
    output logic        vsync_n_o,
    output logic        de_o,
    output logic        blank_n_o,
    output addr_t       vaddr_o
);

    logic       mhz8_en;
    logic       m2_en;
    reg_sel_t   reg_sel;
    logic       reg_wr;
    logic       reg_rd;
    addr_t      vbase;
    logic [7:0] hoff;
    vmode_t     vmode;
    logic       frame_start;

    // ====================
    // Bus side
    clock_enables u_clk_en (.clk32, .porb, .mhz8_en_o(mhz8_en), .m2_en_o(m2_en));

    addr_decode u_decode (
        .a_i, .as_n_i, .rw_i, .uds_n_i, .lds_n_i,
        .rom_n_o, .mfpcs_n_o, .reg_sel_o(reg_sel),
        .reg_wr_o(reg_wr), .reg_rd_o(reg_rd), .dtack_n_o
    );

    bus_error_timer #(.BERR_LIMIT(BERR_LIMIT)) u_berr (
        .clk32, .porb, .mhz8_en_i(mhz8_en), .as_n_i, .br_n_i, .berr_n_o
    );

    shifter_regs u_regs (
        .clk32, .porb, .reg_sel_i(reg_sel), .reg_wr_i(reg_wr), .reg_rd_i(reg_rd),
        .din_i, .vaddr_i(vaddr_o), .dout_o, .vbase_o(vbase), .hoff_o(hoff), .vmode_o(vmode)
    );

    // ====================
    // Video side
    sync_gen u_sync (
        .clk32, .porb, .m2_en_i(m2_en), .vmode_i(vmode),
        .hsync_n_o, .vsync_n_o, .de_o, .blank_n_o, .frame_start_o(frame_start)
    );

    video_addr_counter u_vcnt (
        .clk32, .porb, .m2_en_i(m2_en), .de_i(de_o), .frame_start_i(frame_start),
        .vbase_i(vbase), .hoff_i(hoff), .reg_sel_i(reg_sel), .reg_wr_i(reg_wr),
        .din_i, .vaddr_o
    );

endmodule

/* hw/stmcu_video_pkg.sv */
// Video modes and the per-mode line and frame timing used by the sync generator
package stmcu_video_pkg;

    typedef enum logic [1:0] {
        VM_PAL  = 2'd0,
        VM_NTSC = 2'd1,
        VM_MONO = 2'd2
    } vmode_t;

    typedef logic [7:0] htick_t;  // 2 MHz ticks within a line
    typedef logic [8:0] vline_t;  // Lines within a frame

    localparam htick_t LINE_TICKS_PAL    = 8'd128;
    localparam htick_t LINE_TICKS_NTSC   = 8'd127;
    localparam htick_t LINE_TICKS_MONO   = 8'd56;
    localparam htick_t HSYNC_TICKS_COLOR = 8'd10;
    localparam htick_t HSYNC_TICKS_MONO  = 8'd6;
    localparam vline_t FRAME_LINES_PAL   = 9'd313;
    localparam vline_t FRAME_LINES_NTSC  = 9'd263;
    localparam vline_t FRAME_LINES_MONO  = 9'd501;
    localparam vline_t VSYNC_LINES       = 9'd3;

    // ====================
    // Tables indexed by vmode_t, in the order PAL, NTSC, mono
    localparam htick_t LINE_TICKS [3] = '{LINE_TICKS_PAL, LINE_TICKS_NTSC, LINE_TICKS_MONO};
    localparam htick_t HSYNC_TICKS [3] = '{HSYNC_TICKS_COLOR, HSYNC_TICKS_COLOR, HSYNC_TICKS_MONO};
    localparam vline_t FRAME_LINES [3] = '{FRAME_LINES_PAL, FRAME_LINES_NTSC, FRAME_LINES_MONO};

    localparam htick_t HDE_START [3] = '{8'd16, 8'd15, 8'd4};
    localparam htick_t HDE_END   [3] = '{8'd96, 8'd95, 8'd44};
    localparam vline_t VDE_START [3] = '{9'd63, 9'd34, 9'd36};
    localparam vline_t VDE_END   [3] = '{9'd263, 9'd234, 9'd436};

    // Blank lifts at the END value and comes back at the START value
    localparam htick_t HBLANK_START [3] = '{8'd114, 8'd113, 8'd50};
    localparam htick_t HBLANK_END   [3] = '{8'd9, 8'd8, 8'd1};
    localparam vline_t VBLANK_START [3] = '{9'd308, 9'd258, 9'd500};
    localparam vline_t VBLANK_END   [3] = '{9'd25, 9'd16, 9'd4};

    localparam htick_t WORDS_PER_LINE [3] = '{
        HDE_END[0] - HDE_START[0],
        HDE_END[1] - HDE_START[1],
        HDE_END[2] - HDE_START[2]
    };

endpackage

/* hw/sync_gen.sv */
// Horizontal and vertical timing generator for sync, blank and display enable
`timescale 1ns/1ns

module sync_gen import stmcu_video_pkg::*; (
    input  logic   clk32,
    input  logic   porb,
    input  logic   m2_en_i,
    input  vmode_t vmode_i,
    output logic   hsync_n_o,
    output logic   vsync_n_o,
    output logic   de_o,
    output logic   blank_n_o,
    output logic   frame_start_o
);

    vmode_t mode_q;       // Mode of the running line
    vmode_t mode_next;
    htick_t hcnt, hcnt_next;
    vline_t vcnt, vcnt_next;
    logic   line_end, frame_end;
    logic   h_de, v_de, h_free, v_free;

    // >= so a switch to a shorter mode still wraps
    assign line_end  = hcnt >= LINE_TICKS[mode_q] - 8'd1;
    assign frame_end = vcnt >= FRAME_LINES[mode_q] - 9'd1;

    assign mode_next = line_end ? vmode_i : mode_q;   // Mode only changes at a line start
    assign hcnt_next = line_end ? 8'd0 : hcnt + 8'd1;

    always_comb begin
        if (!line_end)
            vcnt_next = vcnt;
        else if (frame_end)
            vcnt_next = 9'd0;
        else
            vcnt_next = vcnt + 9'd1;
    end

    // ====================
    // Window compares on the position being entered
    assign h_de   = hcnt_next >= HDE_START[mode_next] && hcnt_next < HDE_END[mode_next];
    assign v_de   = vcnt_next >= VDE_START[mode_next] && vcnt_next < VDE_END[mode_next];
    assign h_free = hcnt_next >= HBLANK_END[mode_next] && hcnt_next < HBLANK_START[mode_next];
    assign v_free = vcnt_next >= VBLANK_END[mode_next] && vcnt_next < VBLANK_START[mode_next];

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            // Park on the last tick so the first 2 MHz tick opens a frame
            mode_q        <= VM_NTSC;
            hcnt          <= LINE_TICKS_NTSC - 8'd1;
            vcnt          <= FRAME_LINES_NTSC - 9'd1;
            hsync_n_o     <= 1'b1;
            vsync_n_o     <= 1'b1;
            de_o          <= 1'b0;
            blank_n_o     <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            frame_start_o <= 1'b0;
            if (m2_en_i) begin
                mode_q    <= mode_next;
                hcnt      <= hcnt_next;
                vcnt      <= vcnt_next;
                hsync_n_o <= hcnt_next < LINE_TICKS[mode_next] - HSYNC_TICKS[mode_next];
                vsync_n_o <= vcnt_next >= VSYNC_LINES;  // Low on the first lines
                de_o      <= h_de && v_de;
                blank_n_o <= h_free && v_free;
                frame_start_o <= hcnt_next == 8'd0 && vcnt_next == 9'd0;
            end
        end
    end

endmodule

/* hw/video_addr_counter.sv */
// Video fetch address counter with frame reload, word stepping and line offset
`timescale 1ns/1ns

module video_addr_counter import stmcu_bus_pkg::*; (
    input  logic        clk32,
    input  logic        porb,
    input  logic        m2_en_i,
    input  logic        de_i,
    input  logic        frame_start_i,
    input  addr_t       vbase_i,
    input  logic [7:0]  hoff_i,
    input  reg_sel_t    reg_sel_i,
    input  logic        reg_wr_i,
    input  logic [15:0] din_i,
    output addr_t       vaddr_o
);

    logic de_q;     // Display enable of the previous 2 MHz tick
    logic de_fall;

    assign de_fall = de_q && !de_i;

    always_ff @(posedge clk32 or negedge porb) begin
        if (!porb) begin
            de_q    <= 1'b0;
            vaddr_o <= '0;
        end else begin
            if (m2_en_i) de_q <= de_i;

            // CPU byte writes win over everything else
            if (reg_wr_i && reg_sel_i == REG_CNT_HI)
                vaddr_o[23:16] <= din_i[7:0];
            else if (reg_wr_i && reg_sel_i == REG_CNT_MID)
                vaddr_o[15:8] <= din_i[7:0];
            else if (reg_wr_i && reg_sel_i == REG_CNT_LO)
                vaddr_o[7:1] <= din_i[7:1];
            else if (frame_start_i)
                vaddr_o <= vbase_i;
            else if (m2_en_i && de_fall)
                vaddr_o <= vaddr_o + {15'd0, hoff_i};   // Skip to the next line
            else if (m2_en_i && de_i)
                vaddr_o <= vaddr_o + 23'd1;             // One word per fetch
        end
    end

endmodule

/* tb/stmcu_tb_tasks.svh */
// Bus-cycle tasks, random source and reference models for the MCU testbench
`ifndef STMCU_TB_TASKS_SVH
`define STMCU_TB_TASKS_SVH

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// ====================
// Bus cycles
task automatic start_cycle(input logic [23:0] addr, input logic rw, input logic [7:0] data);
    @(negedge clk32);
    a_i     = addr[23:1];
    rw_i    = rw;
    din_i   = {data, data};     // Same byte on both lanes
    uds_n_i = addr[0];
    lds_n_i = ~addr[0];
    as_n_i  = 1'b0;
endtask

task automatic end_cycle();
    as_n_i  = 1'b1;
    uds_n_i = 1'b1;
    lds_n_i = 1'b1;
    rw_i    = 1'b1;
endtask

task automatic await_dtack(input logic [23:0] addr);
    int waited;
    waited = 0;
    @(negedge clk32);
    while (dtack_n_o !== 1'b0 && waited < DTACK_WAIT) begin
        @(negedge clk32);
        waited++;
    end
    assert (dtack_n_o === 1'b0)
        else report_failure($sformatf("No DTACK within %0d cycles at %h", DTACK_WAIT, addr));
endtask

task automatic write_byte(input logic [23:0] addr, input logic [7:0] data);
    start_cycle(addr, 1'b0, data);
    await_dtack(addr);
    end_cycle();
endtask

task automatic read_word(input logic [23:0] addr, output logic [15:0] data);
    start_cycle(addr, 1'b1, 8'h00);
    await_dtack(addr);
    data = dout_o;
    end_cycle();
endtask

// One strobe cycle, returns {rom_n, mfpcs_n, dtack_n}
task automatic probe_decode(input logic [23:0] addr, output logic [6:0] seen);
    start_cycle(addr, 1'b1, 8'h00);
    @(negedge clk32);
    seen = {rom_n_o, mfpcs_n_o, dtack_n_o};
    end_cycle();
endtask

// ====================
// Address picks and reference models
function automatic logic [23:0] probe_address(input int window);
    logic [31:0] rnd;
    logic [7:0]  hi;
    rnd = next_random();
    case (window)
        0: hi = ROM_TOS_BASE;
        1: hi = ROM_TOS_BASE + 8'h03;
        2: hi = ROM_TOS_BASE + 8'h04;
        3: hi = ROM_TOS_BASE + 8'h07;
        4: hi = ROM_TOS_BASE + 8'h08;
        5: hi = ROM_TOS_BASE + 8'h0B;
        6: hi = ROM_CART_BASE;
        7: hi = ROM_CART_BASE + 8'h01;
        8: hi = 8'hC0;
        10: return MFP_BASE | {18'd0, rnd[5:1], 1'b0};
        default: hi = 8'h40;
    endcase
    return {hi, rnd[15:1], 1'b0};
endfunction

function automatic logic [23:0] reg_address(input int index);
    case (index)
        0: return VREG_BASE + 24'h01;   // Base high
        1: return VREG_BASE + 24'h03;
        2: return VREG_BASE + 24'h0D;   // Base low
        3: return VREG_BASE + 24'h0F;
        4: return VREG_BASE + 24'h0A;   // Sync, upper lane
        default: return VREG_BASE + 24'h60;
    endcase
endfunction

function automatic logic [6:0] decode_model(input logic [23:0] addr);
    logic [4:0] rom_n;
    logic [7:0] tos_off;
    logic       mfp_n;
    rom_n = 5'h1F;
    tos_off = addr[23:16] - ROM_TOS_BASE;
    if (tos_off < 8'd4)
        rom_n[2] = 1'b0;
    else if (tos_off < 8'd8)
        rom_n[1] = 1'b0;
    else if (tos_off < 8'd12)
        rom_n[0] = 1'b0;
    else if (addr[23:16] == ROM_CART_BASE)
        rom_n[4] = 1'b0;
    else if (addr[23:16] == ROM_CART_BASE + 8'h01)
        rom_n[3] = 1'b0;
    mfp_n = !(addr >= MFP_BASE && addr < MFP_BASE + 24'h40);
    return {rom_n, mfp_n, &rom_n};
endfunction

// Written byte sits on both lanes, unused bits read as ones
function automatic logic [15:0] readback_model(input logic [23:0] addr, input logic [7:0] data);
    case (addr[7:0])
        8'h0D: return {8'hFF, data & 8'hFE};
        8'h0A: return {6'h3F, data[1], 9'h1FF};
        8'h60: return {6'h3F, data[1:0], 8'hFF};
        default: return {8'hFF, data};
    endcase
endfunction

`endif

/* tb/stmcu_tb.sv */
// Testbench for the MCU bus decode, video registers and video timing
`timescale 1ns/1ns

module stmcu_tb import stmcu_bus_pkg::*, stmcu_video_pkg::*; ();

    localparam int CLK_HALF     = 50;    // 100 ns period
    localparam int RESET_CYCLES = 5;
    localparam int DTACK_WAIT   = 8;
    localparam int MONO_FRAME   = int'(LINE_TICKS_MONO) * int'(FRAME_LINES_MONO) * 16;
    localparam int PAL_FRAME    = int'(LINE_TICKS_PAL) * int'(FRAME_LINES_PAL) * 16;
    localparam int TIMEOUT_CYCLES = 2 * MONO_FRAME + 2 * PAL_FRAME + 2000;

    logic        clk32;
    logic        porb;
    addr_t       a_i;
    logic        as_n_i, rw_i, uds_n_i, lds_n_i, br_n_i;
    logic [15:0] din_i;
    logic [15:0] dout_o;
    logic        dtack_n_o, berr_n_o, mfpcs_n_o;
    logic [4:0]  rom_n_o;
    logic        hsync_n_o, vsync_n_o, de_o, blank_n_o;
    addr_t       vaddr_o;

    int          cycle_count = 0;
    int          failures = 0;
    logic [31:0] rng_state;
    addr_t       base_word;     // Written base as a word address
    logic [7:0]  hoff_val;
    logic [4:0]  rom_sel;

    stmcu_top #(.BERR_LIMIT(BERR_TICKS)) UUT (
        .clk32(clk32), .porb(porb), .a_i(a_i), .as_n_i(as_n_i), .rw_i(rw_i),
        .uds_n_i(uds_n_i), .lds_n_i(lds_n_i), .br_n_i(br_n_i), .din_i(din_i),
        .dout_o(dout_o), .dtack_n_o(dtack_n_o), .berr_n_o(berr_n_o),
        .rom_n_o(rom_n_o), .mfpcs_n_o(mfpcs_n_o), .hsync_n_o(hsync_n_o),
        .vsync_n_o(vsync_n_o), .de_o(de_o), .blank_n_o(blank_n_o), .vaddr_o(vaddr_o)
    );

    `include "stmcu_tb_tasks.svh"

    task automatic report_failure(input string what);
        failures++;
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("MISMATCH %s: expected 0x%0h, actual 0x%0h",
                                          name, expected, actual));
    endtask

    // ====================
    // Clock, timeout and decoder watch
    initial begin
        clk32 = 1'b0;
        forever #(CLK_HALF) clk32 = ~clk32;
    end

    always @(posedge clk32) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure($sformatf("Timeout, run took more than %0d cycles", TIMEOUT_CYCLES));
    end

    assign rom_sel = ~rom_n_o;

    always @(posedge clk32) begin
        if (porb) begin
            assert ((rom_sel & (rom_sel - 5'd1)) == 5'd0)
                else report_failure("More than one ROM select active at once");
            assert (mfpcs_n_o || dtack_n_o)     // MFP gives its own DTACK
                else report_failure("DTACK driven during an MFP cycle");
        end
    end

    task automatic check_bus_error();
        int held;
        start_cycle(24'h400000, 1'b1, 8'h00);   // Unmapped address that nobody answers
        @(negedge clk32);
        held = 1;
        while (berr_n_o !== 1'b0 && held < BERR_TICKS * 4 + 4) begin
            @(negedge clk32);
            held++;
        end
        assert (berr_n_o === 1'b0)
            else report_failure($sformatf("No bus error within %0d cycles of strobe", held));
        assert (held >= BERR_TICKS * 4 - 4)
            else report_failure($sformatf("Bus error came after only %0d cycles", held));
        end_cycle();
        @(negedge clk32);
        check_value("bus error release", 32'd1, 32'(berr_n_o));
    endtask

    task automatic run_video_checks(input vmode_t mode, input string label);
        int          m;
        int          line_cycles;
        int          lines;
        int          t_start;
        addr_t       expected_addr;
        logic [15:0] hi_w, mid_w, lo_w;
        m = int'(mode);
        line_cycles = int'(LINE_TICKS[m]) * 16;
        lines = int'(VDE_END[m]) - int'(VDE_START[m]);
        // Full frame in the new mode
        while (vsync_n_o !== 1'b1) @(negedge clk32);
        while (vsync_n_o !== 1'b0) @(negedge clk32);
        t_start = cycle_count;
        while (vsync_n_o !== 1'b1) @(negedge clk32);
        check_value({label, " vsync low time"}, int'(VSYNC_LINES) * line_cycles,
                    cycle_count - t_start);
        check_value({label, " frame base"}, 32'(base_word), 32'(vaddr_o));

        while (hsync_n_o !== 1'b1) @(negedge clk32);
        while (hsync_n_o !== 1'b0) @(negedge clk32);
        t_start = cycle_count;
        while (hsync_n_o !== 1'b1) @(negedge clk32);
        while (hsync_n_o !== 1'b0) @(negedge clk32);
        check_value({label, " hsync period"}, line_cycles, cycle_count - t_start);

        for (int i = 0; i < lines; i++) begin
            while (de_o !== 1'b1) @(negedge clk32);
            t_start = cycle_count;
            while (de_o !== 1'b0) @(negedge clk32);
            check_value({label, " de high time"}, int'(WORDS_PER_LINE[m]) * 16,
                        cycle_count - t_start);
        end

        // Blank-free stretch of the line below the display window
        while (blank_n_o !== 1'b0) @(negedge clk32);
        while (blank_n_o !== 1'b1) @(negedge clk32);
        t_start = cycle_count;
        while (blank_n_o !== 1'b0) @(negedge clk32);
        check_value({label, " blank high time"},
                    (int'(HBLANK_START[m]) - int'(HBLANK_END[m])) * 16,
                    cycle_count - t_start);
        while (hsync_n_o !== 1'b0) @(negedge clk32);  // Offset add is done by now

        read_word(VREG_BASE + 24'h05, hi_w);
        read_word(VREG_BASE + 24'h07, mid_w);
        read_word(VREG_BASE + 24'h09, lo_w);
        expected_addr = base_word + addr_t'(lines * (int'(WORDS_PER_LINE[m]) + int'(hoff_val)));
        check_value({label, " counter after display"}, 32'(expected_addr),
                    32'({hi_w[7:0], mid_w[7:0], lo_w[7:1]}));
    endtask

    // ====================
    // Test sequence
    initial begin : main_seq
        logic [23:0] addr;
        logic [31:0] rnd;
        logic [15:0] word;
        logic [6:0]  seen;
        a_i = '0;
        as_n_i = 1'b1;
        rw_i = 1'b1;
        uds_n_i = 1'b1;
        lds_n_i = 1'b1;
        br_n_i = 1'b1;
        din_i = 16'h0000;
        porb = 1'b0;
        rng_state = 32'd34;
        repeat (RESET_CYCLES) @(negedge clk32);
        check_value("reset hsync_n", 32'd1, 32'(hsync_n_o));
        check_value("reset vsync_n", 32'd1, 32'(vsync_n_o));
        check_value("reset de", 32'd0, 32'(de_o));
        porb = 1'b1;

        for (int w = 0; w < 11; w++) begin
            for (int k = 0; k < 3; k++) begin
                addr = probe_address(w);
                probe_decode(addr, seen);
                check_value($sformatf("decode %h", addr), 32'(decode_model(addr)), 32'(seen));
            end
        end

        for (int round = 0; round < 3; round++) begin
            for (int r = 0; r < 6; r++) begin
                addr = reg_address(r);
                rnd = next_random();
                write_byte(addr, rnd[7:0]);
                read_word(addr, word);
                check_value($sformatf("readback %h", addr),
                            32'(readback_model(addr, rnd[7:0])), 32'(word));
            end
        end

        check_bus_error();

        rnd = next_random();
        write_byte(VREG_BASE + 24'h01, rnd[7:0]);
        write_byte(VREG_BASE + 24'h03, rnd[15:8]);
        write_byte(VREG_BASE + 24'h0D, rnd[23:16]);
        write_byte(VREG_BASE + 24'h0F, rnd[31:24]);
        base_word = {rnd[7:0], rnd[15:8], rnd[23:17]};
        hoff_val = rnd[31:24];

        write_byte(VREG_BASE + 24'h60, 8'h02);      // High resolution
        run_video_checks(VM_MONO, "mono");
        write_byte(VREG_BASE + 24'h0A, 8'h02);      // 50 Hz while mono still wins
        write_byte(VREG_BASE + 24'h60, 8'h00);
        run_video_checks(VM_PAL, "pal");

        if (failures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tb
hw/stmcu_bus_pkg.sv
hw/stmcu_video_pkg.sv
hw/clock_enables.sv
hw/addr_decode.sv
hw/bus_error_timer.sv
hw/shifter_regs.sv
hw/sync_gen.sv
hw/video_addr_counter.sv
hw/stmcu_top.sv
tb/stmcu_tb.sv
